//--- filelist.f
verilog/zbus_pkg.sv
verilog/zbus_sync.sv
verilog/port_decode.sv
verilog/zport_regs.sv
verilog/mem_pager.sv
verilog/zfront_top.sv
dv/zfront_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the zfront testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module zfront_tb \
	--Mdir obj_dir \
	-o zfront_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/zfront_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
	exit 0
else
	exit 1
fi

//--- dv/zfront_tb.sv
`timescale 1ns/1ps
`default_nettype none

module zfront_tb;

	import zbus_pkg::*;

	localparam int SYNC_STAGES = 2;
	// edges from the first sampling edge until a write shows on the output
	localparam int WR_LATENCY = SYNC_STAGES + 2;
	// five tests come to about seven hundred cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic       fclk;
	logic       reset;
	logic       iorq_n;
	logic       mreq_n;
	logic       rd_n;
	logic       wr_n;
	zaddr_t     za;
	zdata_t     zd_in;
	zdata_t     zd_out;
	logic       zd_oe;
	zdata_t     border;
	zdata_t     sysconf;
	zdata_t     memconf;
	page_t      page;
	logic       romnram;
	logic       csrom;
	logic [4:0] rom_page;

	// expected register contents
	page_t  exp_page [4];
	zdata_t exp_border;
	zdata_t exp_sysconf;
	zdata_t exp_memconf;

	// border, sysconf, memconf one edge before and at the write latency
	zdata_t snap_pre [3];
	zdata_t snap_post [3];

	// results of the last read cycle
	zdata_t rd_value;
	logic   oe_early;
	logic   oe_on;
	logic   oe_held;
	logic   oe_off;
	logic   oe_seen;

	integer seed;
	int     cycle_count = 0;
	int     err_count = 0;
	int     check_count = 0;
	int     tests_run = 0;

	zfront_top #(
		.SYNC_STAGES(SYNC_STAGES)
	) dut (
		.fclk    (fclk),
		.reset   (reset),
		.iorq_n  (iorq_n),
		.mreq_n  (mreq_n),
		.rd_n    (rd_n),
		.wr_n    (wr_n),
		.za      (za),
		.zd_in   (zd_in),
		.zd_out  (zd_out),
		.zd_oe   (zd_oe),
		.border  (border),
		.sysconf (sysconf),
		.memconf (memconf),
		.page    (page),
		.romnram (romnram),
		.csrom   (csrom),
		.rom_page(rom_page)
	);

	initial fclk = 1'b0;
	always #20 fclk = ~fclk;

	always @(posedge fclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped, no result after %0d cycles", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_data(input string name, input zdata_t got, input zdata_t want);
		check_count++;
		if (got !== want) begin
			$display("FAILED %s: got %h, expected %h", name, got, want);
			err_count++;
		end
	endtask

	task automatic check_page(input string name, input page_t got, input page_t want);
		check_count++;
		if (got !== want) begin
			$display("FAILED %s: got %h, expected %h", name, got, want);
			err_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		check_count++;
		if (got !== want) begin
			$display("FAILED %s: got %h, expected %h", name, got, want);
			err_count++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_count - errs_before);
	endtask

	////////////////////////////////////////
	// register model
	////////////////////////////////////////

	function automatic zaddr_t xt_port(input zdata_t hi);
		return {hi, XT_PORT_LO};
	endfunction

	// kept extended ports in order border, page0..3, sysconf, memconf
	function automatic zdata_t kept_hi(input int n);
		case (n)
			0:       return XT_BORDER;
			5:       return XT_SYSCONF;
			6:       return XT_MEMCONF;
			default: return XT_PAGE0 + 8'(n - 1);
		endcase
	endfunction

	function automatic zdata_t model_read(input zdata_t hi);
		case (hi)
			XT_BORDER:  return exp_border;
			XT_SYSCONF: return exp_sysconf;
			XT_MEMCONF: return exp_memconf;
			default:    return exp_page[2'(hi - XT_PAGE0)];
		endcase
	endfunction

	task automatic model_write(input zdata_t hi, input zdata_t data);
		case (hi)
			XT_BORDER:  exp_border = data;
			XT_SYSCONF: exp_sysconf = data;
			XT_MEMCONF: exp_memconf = data;
			default:    exp_page[2'(hi - XT_PAGE0)] = data;
		endcase
	endtask

	////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////

	// edge 1 of the loop is the first edge that sees the cycle
	task automatic io_write(input zaddr_t addr, input zdata_t data);
		za     <= addr;
		zd_in  <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		for (int i = 1; i < 10; i++) begin
			@(posedge fclk);
			@(negedge fclk);
			if (i == WR_LATENCY)
				snap_pre = '{border, sysconf, memconf};
			if (i == WR_LATENCY + 1)
				snap_post = '{border, sysconf, memconf};
		end
		@(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		repeat (6) @(posedge fclk);
	endtask

	task automatic io_read(input zaddr_t addr);
		oe_seen = 1'b0;
		za     <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		for (int i = 1; i < 10; i++) begin
			@(posedge fclk);
			@(negedge fclk);
			oe_seen = oe_seen | zd_oe;
			if (i == WR_LATENCY)
				oe_early = zd_oe;
			if (i == WR_LATENCY + 1) begin
				oe_on = zd_oe;
				rd_value = zd_out;
			end
			if (i == 9)
				oe_held = zd_oe;
		end
		@(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		for (int j = 1; j < 6; j++) begin
			@(posedge fclk);
			@(negedge fclk);
			oe_seen = oe_seen | zd_oe;
			if (j == 4)
				oe_off = zd_oe;
		end
		@(posedge fclk);
	endtask

	task automatic mem_access(input zaddr_t addr, input logic mreq);
		win_t w;
		logic rom_exp;
		w = addr[15:14];
		rom_exp = (w == 2'd0) && !exp_memconf[MEMCONF_W0_RAM];
		za     <= addr;
		mreq_n <= mreq;
		@(posedge fclk);
		@(negedge fclk);
		check_page("page", page, exp_page[w]);
		check_page("rom_page", {3'b000, rom_page}, {3'b000, exp_page[w][4:0]});
		check_bit("romnram", romnram, rom_exp);
		check_bit("csrom", csrom, rom_exp & ~mreq);
		@(posedge fclk);
		mreq_n <= 1'b1;
	endtask

	task automatic read_check(input zdata_t hi);
		io_read(xt_port(hi));
		check_data("zd_out", rd_value, model_read(hi));
		check_bit("zd_oe", oe_on, 1'b1);
	endtask

	task automatic read_all();
		for (int n = 0; n < 7; n++)
			read_check(kept_hi(n));
	endtask

	task automatic check_timing(input string name, input logic [1:0] idx,
			input zdata_t old, input zdata_t want);
		check_data({name, " one edge early"}, snap_pre[idx], old);
		check_data({name, " at latency"}, snap_post[idx], want);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic test_reset();
		int errs;
		errs = err_count;
		check_data("border", border, 8'h00);
		check_data("sysconf", sysconf, 8'h00);
		check_data("memconf", memconf, 8'h00);
		check_bit("zd_oe", zd_oe, 1'b0);
		check_bit("csrom", csrom, 1'b0);
		read_all();
		end_test("reset values", errs);
	endtask

	task automatic test_ext_regs();
		int     errs;
		zdata_t hi;
		zdata_t data;
		zdata_t old;
		errs = err_count;
		for (int n = 0; n < 7; n++) begin
			hi = kept_hi(n);
			data = zdata_t'($random(seed));
			old = model_read(hi);
			io_write(xt_port(hi), data);
			model_write(hi, data);
			case (hi)
				XT_BORDER:  check_timing("border", 2'd0, old, data);
				XT_SYSCONF: check_timing("sysconf", 2'd1, old, data);
				XT_MEMCONF: check_timing("memconf", 2'd2, old, data);
				default: ;
			endcase
		end
		check_data("border", border, exp_border);
		check_data("sysconf", sysconf, exp_sysconf);
		read_all();
		end_test("extended registers", errs);
	endtask

	task automatic test_classic_border();
		int     errs;
		zdata_t data;
		zdata_t old;
		errs = err_count;
		data = zdata_t'($random(seed));
		old = exp_border;
		io_write({zdata_t'($random(seed)), 8'hFE}, data);
		exp_border = {ZBORDER_FILL, data[2:0]};
		check_timing("border", 2'd0, old, exp_border);
		// odd address and an unknown extended code
		io_write(16'h7FFD, zdata_t'($random(seed)));
		io_write(xt_port(8'h30), zdata_t'($random(seed)));
		check_data("border", border, exp_border);
		check_data("sysconf", sysconf, exp_sysconf);
		check_data("memconf", memconf, exp_memconf);
		read_all();
		io_read(xt_port(8'h22));
		if (oe_seen) begin
			$display("zd_oe went high on a read of an unused extended port");
			err_count++;
		end
		io_read(16'h00FE);
		if (oe_seen) begin
			$display("zd_oe went high on a read of the write only border port");
			err_count++;
		end
		end_test("classic border", errs);
	endtask

	task automatic test_pager();
		int     errs;
		zdata_t data;
		errs = err_count;
		for (int w = 0; w < 4; w++) begin
			data = zdata_t'($random(seed));
			io_write(xt_port(XT_PAGE0 + 8'(w)), data);
			model_write(XT_PAGE0 + 8'(w), data);
		end
		data = zdata_t'($random(seed));
		data[MEMCONF_W0_RAM] = 1'b0;
		io_write(xt_port(XT_MEMCONF), data);
		model_write(XT_MEMCONF, data);
		for (int w = 0; w < 4; w++)
			mem_access({win_t'(w), 14'($random(seed))}, 1'b0);
		mem_access({2'd0, 14'($random(seed))}, 1'b1);
		// ram in window 0
		data[MEMCONF_W0_RAM] = 1'b1;
		io_write(xt_port(XT_MEMCONF), data);
		model_write(XT_MEMCONF, data);
		for (int w = 0; w < 4; w++)
			mem_access({win_t'(w), 14'($random(seed))}, 1'b0);
		end_test("pager", errs);
	endtask

	task automatic test_read_enable();
		int errs;
		errs = err_count;
		for (int n = 0; n < 7; n += 5) begin
			io_read(xt_port(kept_hi(n)));
			check_bit("zd_oe before latency", oe_early, 1'b0);
			check_bit("zd_oe at latency", oe_on, 1'b1);
			check_bit("zd_oe until release", oe_held, 1'b1);
			check_bit("zd_oe 4 cycles after release", oe_off, 1'b0);
			check_data("zd_out", rd_value, model_read(kept_hi(n)));
		end
		end_test("read enable", errs);
	endtask

	initial begin
		seed   = 32'h80a1_ff16;
		reset  = 1'b1;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		za     = '0;
		zd_in  = '0;
		repeat (16) @(posedge fclk);
		reset <= 1'b0;
		@(posedge fclk);
		exp_page    = '{PAGE_RESET[0], PAGE_RESET[1], PAGE_RESET[2], PAGE_RESET[3]};
		exp_border  = 8'h00;
		exp_sysconf = 8'h00;
		exp_memconf = 8'h00;
		test_reset();
		test_ext_regs();
		test_classic_border();
		test_pager();
		test_read_enable();
		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/zfront_top.sv
`timescale 1ns/1ps
`default_nettype none

module zfront_top #(
	parameter int SYNC_STAGES = 2
) (
	input  wire                   fclk,
	input  wire                   reset,
	input  wire                   iorq_n,
	input  wire                   mreq_n,
	input  wire                   rd_n,
	input  wire                   wr_n,
	input  wire zbus_pkg::zaddr_t za,
	input  wire zbus_pkg::zdata_t zd_in,
	output wire zbus_pkg::zdata_t zd_out,
	output wire                   zd_oe,
	output wire zbus_pkg::zdata_t border,
	output wire zbus_pkg::zdata_t sysconf,
	output wire zbus_pkg::zdata_t memconf,
	output wire zbus_pkg::page_t  page,
	output wire                   romnram,
	output wire                   csrom,
	output wire [4:0]             rom_page
);

	import zbus_pkg::*;

	// sync to decode
	wire    io_wr_s;
	wire    io_rd_s;
	wire    io_active;
	zaddr_t cap_addr;
	zdata_t cap_data;

	// decode to registers
	wire    wr_stb;
	wire    rd_stb;
	zport_e port_sel;
	zdata_t wr_data;
	wire    io_active_d;

	// registers to pager
	page_t  xt_page0;
	page_t  xt_page1;
	page_t  xt_page2;
	page_t  xt_page3;

	////////////////////////////////////////
	// i/o pipeline
	////////////////////////////////////////

	zbus_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) zbus_sync (
		.fclk     (fclk),
		.reset    (reset),
		.iorq_n   (iorq_n),
		.rd_n     (rd_n),
		.wr_n     (wr_n),
		.za       (za),
		.zd_in    (zd_in),
		.io_wr_s  (io_wr_s),
		.io_rd_s  (io_rd_s),
		.io_active(io_active),
		.cap_addr (cap_addr),
		.cap_data (cap_data)
	);

	port_decode port_decode (
		.fclk       (fclk),
		.reset      (reset),
		.io_wr_s    (io_wr_s),
		.io_rd_s    (io_rd_s),
		.io_active  (io_active),
		.cap_addr   (cap_addr),
		.cap_data   (cap_data),
		.wr_stb     (wr_stb),
		.rd_stb     (rd_stb),
		.port_sel   (port_sel),
		.wr_data    (wr_data),
		.io_active_d(io_active_d)
	);

	zport_regs zport_regs (
		.fclk       (fclk),
		.reset      (reset),
		.wr_stb     (wr_stb),
		.rd_stb     (rd_stb),
		.port_sel   (port_sel),
		.wr_data    (wr_data),
		.io_active_d(io_active_d),
		.border     (border),
		.sysconf    (sysconf),
		.memconf    (memconf),
		.xt_page0   (xt_page0),
		.xt_page1   (xt_page1),
		.xt_page2   (xt_page2),
		.xt_page3   (xt_page3),
		.zd_out     (zd_out),
		.zd_oe      (zd_oe)
	);

	////////////////////////////////////////
	// memory pager
	////////////////////////////////////////

	mem_pager mem_pager (
		.fclk    (fclk),
		.reset   (reset),
		.za      (za),
		.mreq_n  (mreq_n),
		.memconf (memconf),
		.xt_page0(xt_page0),
		.xt_page1(xt_page1),
		.xt_page2(xt_page2),
		.xt_page3(xt_page3),
		.page    (page),
		.romnram (romnram),
		.csrom   (csrom),
		.rom_page(rom_page)
	);

endmodule

`default_nettype wire

//--- verilog/mem_pager.sv
`timescale 1ns/1ps
`default_nettype none

module mem_pager (
	input  wire                   fclk,
	input  wire                   reset,
	input  wire zbus_pkg::zaddr_t za,
	input  wire                   mreq_n,
	input  wire zbus_pkg::zdata_t memconf,
	input  wire zbus_pkg::page_t  xt_page0,
	input  wire zbus_pkg::page_t  xt_page1,
	input  wire zbus_pkg::page_t  xt_page2,
	input  wire zbus_pkg::page_t  xt_page3,
	output zbus_pkg::page_t       page,
	output logic                  romnram,
	output logic                  csrom,
	output logic [4:0]            rom_page
);

	import zbus_pkg::*;

	win_t  win;
	page_t win_page;
	logic  rom_win;

	assign win = za[15:14];

	always_comb begin
		case (win)
			2'd0:    win_page = xt_page0;
			2'd1:    win_page = xt_page1;
			2'd2:    win_page = xt_page2;
			default: win_page = xt_page3;
		endcase
	end

	// rom only ever sits in window 0
	assign rom_win = (win == 2'd0) && !memconf[MEMCONF_W0_RAM];

	always_ff @(posedge fclk) begin
		page <= win_page;
	end

	always_ff @(posedge fclk) begin
		if (reset) begin
			romnram <= 1'b0;
			csrom   <= 1'b0;
		end else begin
			romnram <= rom_win;
			csrom   <= rom_win & ~mreq_n;
		end
	end

	// rom chip page lines
	assign rom_page = page[4:0];

endmodule

`default_nettype wire

//--- verilog/zport_regs.sv
`timescale 1ns/1ps
`default_nettype none

module zport_regs (
	input  wire                   fclk,
	input  wire                   reset,
	input  wire                   wr_stb,
	input  wire                   rd_stb,
	input  wire zbus_pkg::zport_e port_sel,
	input  wire zbus_pkg::zdata_t wr_data,
	input  wire                   io_active_d,
	output zbus_pkg::zdata_t      border,
	output zbus_pkg::zdata_t      sysconf,
	output zbus_pkg::zdata_t      memconf,
	output zbus_pkg::page_t       xt_page0,
	output zbus_pkg::page_t       xt_page1,
	output zbus_pkg::page_t       xt_page2,
	output zbus_pkg::page_t       xt_page3,
	output zbus_pkg::zdata_t      zd_out,
	output logic                  zd_oe
);

	import zbus_pkg::*;

	zdata_t rd_mux;

	////////////////////////////////////////
	// register writes
	////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (reset) begin
			border   <= '0;
			sysconf  <= '0;
			memconf  <= '0;
			xt_page0 <= PAGE_RESET[0];
			xt_page1 <= PAGE_RESET[1];
			xt_page2 <= PAGE_RESET[2];
			xt_page3 <= PAGE_RESET[3];
		end else if (wr_stb) begin
			case (port_sel)
				PORT_ZBORDER: border   <= {ZBORDER_FILL, wr_data[2:0]};
				PORT_BORDER:  border   <= wr_data;
				PORT_PAGE0:   xt_page0 <= wr_data;
				PORT_PAGE1:   xt_page1 <= wr_data;
				PORT_PAGE2:   xt_page2 <= wr_data;
				PORT_PAGE3:   xt_page3 <= wr_data;
				PORT_SYSCONF: sysconf  <= wr_data;
				PORT_MEMCONF: memconf  <= wr_data;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// read back
	////////////////////////////////////////

	always_comb begin
		case (port_sel)
			PORT_BORDER:  rd_mux = border;
			PORT_PAGE0:   rd_mux = xt_page0;
			PORT_PAGE1:   rd_mux = xt_page1;
			PORT_PAGE2:   rd_mux = xt_page2;
			PORT_PAGE3:   rd_mux = xt_page3;
			PORT_SYSCONF: rd_mux = sysconf;
			PORT_MEMCONF: rd_mux = memconf;
			default:      rd_mux = 8'hFF;
		endcase
	end

	always_ff @(posedge fclk) begin
		if (rd_stb)
			zd_out <= rd_mux;
	end

	// drive until iorq goes away
	always_ff @(posedge fclk) begin
		if (reset)
			zd_oe <= 1'b0;
		else if (rd_stb)
			zd_oe <= 1'b1;
		else if (!io_active_d)
			zd_oe <= 1'b0;
	end

	// bus only driven for a readable register
	a_oe_from_read: assert property (@(posedge fclk) disable iff (reset)
		$rose(zd_oe) |-> $past(rd_stb) && $past(port_sel) != PORT_NONE
			&& $past(port_sel) != PORT_ZBORDER);

endmodule

`default_nettype wire

//--- verilog/port_decode.sv
`timescale 1ns/1ps
`default_nettype none

module port_decode (
	input  wire                   fclk,
	input  wire                   reset,
	input  wire                   io_wr_s,
	input  wire                   io_rd_s,
	input  wire                   io_active,
	input  wire zbus_pkg::zaddr_t cap_addr,
	input  wire zbus_pkg::zdata_t cap_data,
	output logic                  wr_stb,
	output logic                  rd_stb,
	output zbus_pkg::zport_e      port_sel,
	output zbus_pkg::zdata_t      wr_data,
	output logic                  io_active_d
);

	import zbus_pkg::*;

	zport_e port_dec;
	logic   port_hit;

	////////////////////////////////////////
	// address match
	////////////////////////////////////////

	always_comb begin
		port_dec = PORT_NONE;
		if (cap_addr[7:0] == XT_PORT_LO) begin
			case (cap_addr[15:8])
				XT_BORDER:        port_dec = PORT_BORDER;
				XT_PAGE0:         port_dec = PORT_PAGE0;
				XT_PAGE0 + 8'd1:  port_dec = PORT_PAGE1;
				XT_PAGE0 + 8'd2:  port_dec = PORT_PAGE2;
				XT_PAGE0 + 8'd3:  port_dec = PORT_PAGE3;
				XT_SYSCONF:       port_dec = PORT_SYSCONF;
				XT_MEMCONF:       port_dec = PORT_MEMCONF;
				default:          port_dec = PORT_NONE;
			endcase
		end else if (!cap_addr[0] && io_wr_s) begin
			// classic #FE, write only, a0 alone decides
			port_dec = PORT_ZBORDER;
		end
	end

	assign port_hit = (port_dec != PORT_NONE);

	always_ff @(posedge fclk) begin
		if (reset) begin
			wr_stb      <= 1'b0;
			rd_stb      <= 1'b0;
			port_sel    <= PORT_NONE;
			io_active_d <= 1'b0;
		end else begin
			wr_stb      <= io_wr_s & port_hit;
			rd_stb      <= io_rd_s & port_hit;
			io_active_d <= io_active;
			if (io_wr_s | io_rd_s)
				port_sel <= port_dec;
		end
	end

	always_ff @(posedge fclk) begin
		if (io_wr_s)
			wr_data <= cap_data;
	end

	// unmatched ports must stay silent downstream
	// and the #fe port never sees a read
	a_stb_has_port: assert property (@(posedge fclk) disable iff (reset)
		(wr_stb || rd_stb) |-> (port_sel != PORT_NONE)
			&& !(rd_stb && port_sel == PORT_ZBORDER));

endmodule

`default_nettype wire

//--- verilog/zbus_sync.sv
`timescale 1ns/1ps
`default_nettype none

module zbus_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  wire                   fclk,
	input  wire                   reset,
	input  wire                   iorq_n,
	input  wire                   rd_n,
	input  wire                   wr_n,
	input  wire zbus_pkg::zaddr_t za,
	input  wire zbus_pkg::zdata_t zd_in,
	output logic                  io_wr_s,
	output logic                  io_rd_s,
	output logic                  io_active,
	output zbus_pkg::zaddr_t      cap_addr,
	output zbus_pkg::zdata_t      cap_data
);

	// strobes as active high levels, oldest stage on top
	logic [SYNC_STAGES-1:0] iorq_sync;
	logic [SYNC_STAGES-1:0] rd_sync;
	logic [SYNC_STAGES-1:0] wr_sync;

	logic io_wr_lvl;
	logic io_rd_lvl;
	logic io_wr_prev;
	logic io_rd_prev;
	logic io_wr_rise;
	logic io_rd_rise;

	always_ff @(posedge fclk) begin
		if (reset) begin
			iorq_sync <= '0;
			rd_sync   <= '0;
			wr_sync   <= '0;
		end else begin
			iorq_sync <= SYNC_STAGES'({iorq_sync, ~iorq_n});
			rd_sync   <= SYNC_STAGES'({rd_sync, ~rd_n});
			wr_sync   <= SYNC_STAGES'({wr_sync, ~wr_n});
		end
	end

	assign io_active = iorq_sync[SYNC_STAGES-1];
	assign io_wr_lvl = iorq_sync[SYNC_STAGES-1] & wr_sync[SYNC_STAGES-1];
	assign io_rd_lvl = iorq_sync[SYNC_STAGES-1] & rd_sync[SYNC_STAGES-1];

	assign io_wr_rise = io_wr_lvl & ~io_wr_prev;
	assign io_rd_rise = io_rd_lvl & ~io_rd_prev;

	// start of cycle strobes
	always_ff @(posedge fclk) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
			io_rd_prev <= 1'b0;
			io_wr_s    <= 1'b0;
			io_rd_s    <= 1'b0;
		end else begin
			io_wr_prev <= io_wr_lvl;
			io_rd_prev <= io_rd_lvl;
			io_wr_s    <= io_wr_rise;
			io_rd_s    <= io_rd_rise;
		end
	end

	// address and data are stable by the time the strobes are synced
	always_ff @(posedge fclk) begin
		if (io_wr_rise | io_rd_rise) begin
			cap_addr <= za;
			cap_data <= zd_in;
		end
	end

	// z80 never drives rd_n and wr_n low in the same i/o cycle
	a_no_rd_wr: assert property (@(posedge fclk) disable iff (reset)
		!(io_wr_s && io_rd_s));

endmodule

`default_nettype wire

//--- verilog/zbus_pkg.sv
`default_nettype none

package zbus_pkg;

	// z80 bus widths
	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;
	typedef logic [7:0]  page_t;

	// window index is a15:a14
	typedef logic [1:0]  win_t;

	// decoded port
	typedef enum logic [3:0] {
		PORT_NONE,
		PORT_ZBORDER,
		PORT_BORDER,
		PORT_PAGE0,
		PORT_PAGE1,
		PORT_PAGE2,
		PORT_PAGE3,
		PORT_SYSCONF,
		PORT_MEMCONF
	} zport_e;

	////////////////////////////////////////
	// extended port codes
	////////////////////////////////////////

	// low byte shared by all #xxAF ports
	localparam zdata_t XT_PORT_LO = 8'hAF;

	// high byte, pages 1..3 follow page 0
	localparam zdata_t XT_BORDER  = 8'h0F;
	localparam zdata_t XT_PAGE0   = 8'h10;
	localparam zdata_t XT_SYSCONF = 8'h20;
	localparam zdata_t XT_MEMCONF = 8'h21;

	////////////////////////////////////////
	// register reset values
	////////////////////////////////////////

	// upper border bits on a #FE write
	localparam logic [4:0] ZBORDER_FILL = 5'b11110;

	// windows 3..0 after reset
	localparam page_t [3:0] PAGE_RESET = {8'h00, 8'h02, 8'h05, 8'h00};

	// memconf bit that maps ram into window 0
	localparam int MEMCONF_W0_RAM = 3;

endpackage

`default_nettype wire
